// File: project.f
hdl/doe_cipher_pkg.sv
hdl/doe_ctrl_pkg.sv
hdl/doe_key_mem.sv
hdl/doe_encipher_block.sv
hdl/doe_decipher_block.sv
hdl/doe_core_cbc.sv
test/doe_core_cbc_properties.sv
test/tb_doe_core_cbc.sv

// File: test/tb_doe_core_cbc.sv
// Drives the DOE AES-128 CBC core; stops at the first mismatch; needs the bound properties
`timescale 1ns/1ps
`default_nettype none

module tb_doe_core_cbc import doe_cipher_pkg::*, doe_ctrl_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CMDS     = 34;
  // Every command gets 20 cycles, plus reset and a margin
  localparam int WATCHDOG_NS  = (NUM_CMDS * 20 + RESET_CYCLES) * CLK_PERIOD + 4000;

  logic        clk;
  logic        reset_n;
  doe_cmd_t    cmd;
  doe_block_u  key;
  doe_block_u  iv;
  doe_block_u  block_msg;
  doe_block_u  result;
  doe_status_t status;

  // Software view of the chain, key and random state
  doe_block_u  sw_chain;
  doe_block_u  cur_key;
  logic [31:0] lcg_state;

  // Expected results in issue order
  doe_block_u  exp_q [$];
  int          expected_total;
  int          checked_total;
  logic        valid_seen;

  doe_core_cbc u_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .key       (key),
    .iv        (iv),
    .block_msg (block_msg),
    .result    (result),
    .status    (status)
  );

  // ----------------------------------------
  // Error reporting and compare tasks
  // ----------------------------------------
  task automatic fail_run();
    $display("TB FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_block(input string name, input doe_block_u got, input doe_block_u exp);
    if (got !== exp)
    begin
      $display("[FAIL] time=%0t %s: got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_status(input string name, input doe_status_t got,
                              input doe_status_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] time=%0t %s: got %b expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic doe_block_u xor_block(input doe_block_u a, input doe_block_u b);
    doe_block_u r;
    r.words = a.words ^ b.words;
    return r;
  endfunction

  // FIPS-197 byte order, s[4*c + r] is row r of column c
  function automatic doe_block_u ref_aes128_encrypt(input doe_block_u k, input doe_block_u pt);
    logic [127:0] kv;
    logic [127:0] pv;
    logic [127:0] cv;
    logic [31:0]  w [0:43];
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [31:0]  tmp;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    kv = k;
    pv = pt;
    // Software key schedule, 44 words
    for (int i = 0; i < 4; i++)
      w[i] = kv[127 - 32 * i -: 32];
    for (int i = 4; i < 44; i++)
    begin
      tmp = w[i - 1];
      if (i % 4 == 0)
        tmp = {doe_sbox(tmp[23:16]), doe_sbox(tmp[15:8]), doe_sbox(tmp[7:0]),
               doe_sbox(tmp[31:24])} ^ {doe_rcon(doe_round_t'(i / 4)), 24'h000000};
      w[i] = w[i - 4] ^ tmp;
    end
    for (int i = 0; i < 16; i++)
      s[i] = pv[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
    for (int rnd = 1; rnd <= DOE_NUM_ROUNDS; rnd++)
    begin
      // Substitute and shift rows in one pass
      for (int c = 0; c < 4; c++)
        for (int r = 0; r < 4; r++)
          t[4 * c + r] = doe_sbox(s[4 * ((c + r) % 4) + r]);
      for (int c = 0; c < 4; c++)
      begin
        a0 = t[4 * c];
        a1 = t[4 * c + 1];
        a2 = t[4 * c + 2];
        a3 = t[4 * c + 3];
        if (rnd == DOE_NUM_ROUNDS)
        begin
          s[4 * c]     = a0;
          s[4 * c + 1] = a1;
          s[4 * c + 2] = a2;
          s[4 * c + 3] = a3;
        end
        else
        begin
          s[4 * c]     = doe_gmul(a0, 4'd2) ^ doe_gmul(a1, 4'd3) ^ a2 ^ a3;
          s[4 * c + 1] = a0 ^ doe_gmul(a1, 4'd2) ^ doe_gmul(a2, 4'd3) ^ a3;
          s[4 * c + 2] = a0 ^ a1 ^ doe_gmul(a2, 4'd2) ^ doe_gmul(a3, 4'd3);
          s[4 * c + 3] = doe_gmul(a0, 4'd3) ^ a1 ^ a2 ^ doe_gmul(a3, 4'd2);
        end
      end
      for (int i = 0; i < 16; i++)
        s[i] = s[i] ^ w[4 * rnd + i / 4][31 - 8 * (i % 4) -: 8];
    end
    for (int i = 0; i < 16; i++)
      cv[127 - 8 * i -: 8] = s[i];
    return cv;
  endfunction

  // Numerical Recipes LCG constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand_block(output doe_block_u b);
    for (int i = 0; i < 4; i++)
    begin
      lcg_state  = lcg_next(lcg_state);
      b.words[i] = lcg_state;
    end
  endtask

  // ----------------------------------------
  // Command tasks, all at 2 ns past the edge
  // ----------------------------------------
  task automatic wait_ready();
    while (!status.ready)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic pulse_cmd(input doe_cmd_t c);
    cmd = c;
    @(posedge clk);
    #2;
    cmd = '0;
  endtask

  // Issued while busy, must leave status untouched
  task automatic pulse_ignored(input logic init, input logic next);
    doe_block_u junk;
    rand_block(junk);
    if (status.ready)
    begin
      $display("Ignored command was meant for a busy core, but the core was ready");
      fail_run();
    end
    // Key only moves with the dropped init, an expansion in flight keeps its key
    if (init)
      key = junk;
    block_msg = junk;
    pulse_cmd('{encdec: 1'b1, init: init, next: next, iv_load: 1'b0});
    check_status("status", status, '{ready: 1'b0, result_valid: 1'b0});
  endtask

  task automatic start_init(input doe_block_u k);
    wait_ready();
    key     = k;
    cur_key = k;
    pulse_cmd('{encdec: 1'b0, init: 1'b1, next: 1'b0, iv_load: 1'b0});
  endtask

  task automatic load_iv(input doe_block_u v);
    wait_ready();
    iv       = v;
    sw_chain = v;
    pulse_cmd('{encdec: 1'b0, init: 1'b0, next: 1'b0, iv_load: 1'b1});
  endtask

  task automatic send_next(input logic enc, input doe_block_u msg, input logic with_iv,
                           input doe_block_u new_iv, input doe_block_u expected);
    wait_ready();
    block_msg = msg;
    if (with_iv)
      iv = new_iv;
    exp_q.push_back(expected);
    expected_total++;
    pulse_cmd('{encdec: enc, init: 1'b0, next: 1'b1, iv_load: with_iv});
  endtask

  // CBC: ciphertext is E(plaintext XOR previous ciphertext)
  task automatic encrypt_block(input doe_block_u pt, input logic with_iv,
                               input doe_block_u new_iv, output doe_block_u ct);
    if (with_iv)
      sw_chain = new_iv;
    ct       = ref_aes128_encrypt(cur_key, xor_block(pt, sw_chain));
    sw_chain = ct;
    send_next(1'b1, pt, with_iv, new_iv, ct);
  endtask

  task automatic decrypt_block(input doe_block_u ct, input doe_block_u pt);
    sw_chain = ct;
    send_next(1'b0, ct, 1'b0, '0, pt);
  endtask

  // ----------------------------------------
  // Clock, watchdog and monitors
  // ----------------------------------------
  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run took longer than its commands allow");
    fail_run();
  end

  // Compare each new result against the oldest expectation
  initial
  begin
    valid_seen    = 1'b0;
    checked_total = 0;
    forever
    begin
      @(negedge clk);
      if (status.result_valid && !valid_seen)
      begin
        if (exp_q.size() == 0)
        begin
          $display("result_valid rose at %0t with no block outstanding", $time);
          fail_run();
        end
        check_block("result", result, exp_q.pop_front());
        checked_total++;
      end
      valid_seen = status.result_valid;
    end
  end

  // Assertion failures in the bound checker end the run
  always @(negedge clk)
  begin
    if (u_dut.u_props.violations != 0)
    begin
      $display("A control property of the DUT was violated at %0t", $time);
      fail_run();
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin
    doe_block_u pts [8];
    doe_block_u cts [8];
    doe_block_u rkey;
    doe_block_u riv;
    doe_block_u pt;
    doe_block_u ct;
    reset_n        = 1'b0;
    cmd            = '0;
    key            = '0;
    iv             = '0;
    block_msg      = '0;
    sw_chain       = '0;
    cur_key        = '0;
    expected_total = 0;
    lcg_state      = 32'h58ec_8d5d;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset_n = 1'b1;
    check_status("status", status, '{ready: 1'b1, result_valid: 1'b0});

    // FIPS-197 appendix vector, zero IV
    pt = 128'h3243f6a8885a308d313198a2e0370734;
    check_block("ref_aes128_encrypt", ref_aes128_encrypt(128'h2b7e151628aed2a6abf7158809cf4f3c,
                pt), 128'h3925841d02dc09fbdc118597196a0b32);
    start_init(128'h2b7e151628aed2a6abf7158809cf4f3c);
    encrypt_block(pt, 1'b1, '0, ct);

    // Eight-block CBC stream, IV loaded with the first next
    rand_block(rkey);
    rand_block(riv);
    start_init(rkey);
    for (int i = 0; i < 8; i++)
    begin
      rand_block(pts[i]);
      encrypt_block(pts[i], i == 0, riv, cts[i]);
    end

    // Same stream back to plaintext
    load_iv(riv);
    for (int i = 0; i < 8; i++)
      decrypt_block(cts[i], pts[i]);

    // Chain restarts on a separate IV load, then on one tied to next
    for (int i = 0; i < 2; i++)
    begin
      rand_block(pt);
      encrypt_block(pt, 1'b0, '0, ct);
    end
    rand_block(riv);
    load_iv(riv);
    for (int i = 0; i < 2; i++)
    begin
      rand_block(pt);
      encrypt_block(pt, 1'b0, '0, ct);
    end
    rand_block(riv);
    rand_block(pt);
    encrypt_block(pt, 1'b1, riv, ct);

    // Busy core drops init and next, old key stays in use
    rand_block(pt);
    encrypt_block(pt, 1'b0, '0, ct);
    pulse_ignored(1'b1, 1'b0);
    pulse_ignored(1'b0, 1'b1);
    rand_block(pt);
    encrypt_block(pt, 1'b0, '0, ct);

    // Re-init with a new key, next during expansion is dropped
    rand_block(rkey);
    start_init(rkey);
    pulse_ignored(1'b0, 1'b1);
    for (int i = 0; i < 2; i++)
    begin
      rand_block(pt);
      encrypt_block(pt, 1'b0, '0, ct);
    end

    wait_ready();
    repeat (2) @(negedge clk);
    if (exp_q.size() == 0 && checked_total == expected_total)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("Run ended with %0d of %0d results checked", checked_total, expected_total);
      fail_run();
    end
  end

endmodule

`default_nettype wire

// File: test/doe_core_cbc_properties.sv
// Control checks for the CBC core; bound into every doe_core_cbc, counts failures in violations
`timescale 1ns/1ps
`default_nettype none

module doe_core_cbc_properties import doe_cipher_pkg::*, doe_ctrl_pkg::*;
(
  input wire             clk,
  input wire             reset_n,
  input doe_cmd_t        cmd,
  input doe_block_u      result,
  input doe_status_t     status,
  input doe_ctrl_state_e state_q
);

  // Failed assertions so far
  int violations = 0;

  // ----------------------------------------
  // Status properties
  // ----------------------------------------

  // A valid result only shows with the core idle
  property valid_implies_ready;
    @(posedge clk) disable iff (!reset_n)
      status.result_valid |-> status.ready;
  endproperty

  // Accepted init or next takes the core busy
  property accept_clears_ready;
    @(posedge clk) disable iff (!reset_n)
      (state_q == IDLE && (cmd.init || cmd.next)) |=> !status.ready;
  endproperty

  // Result holds for as long as it is valid
  property result_held;
    @(posedge clk) disable iff (!reset_n)
      status.result_valid |=> (!status.result_valid || $stable(result));
  endproperty

  // Longest busy stretch is a full block, 12 cycles
  property busy_bounded;
    @(posedge clk) disable iff (!reset_n)
      $fell(status.ready) |-> ##[1:12] status.ready;
  endproperty

  a_valid_implies_ready: assert property (valid_implies_ready)
  else
  begin
    violations++;
    $error("result_valid high while ready low");
  end

  a_accept_clears_ready: assert property (accept_clears_ready)
  else
  begin
    violations++;
    $error("ready still high after an accepted command");
  end

  a_result_held: assert property (result_held)
  else
  begin
    violations++;
    $error("result changed while result_valid high");
  end

  a_busy_bounded: assert property (busy_bounded)
  else
  begin
    violations++;
    $error("ready low for more than 12 cycles");
  end

endmodule

// Attach to the top level, FSM state taken from inside
bind doe_core_cbc doe_core_cbc_properties u_props (
  .clk     (clk),
  .reset_n (reset_n),
  .cmd     (cmd),
  .result  (result),
  .status  (status),
  .state_q (state_q)
);

`default_nettype wire

// File: hdl/doe_core_cbc.sv
// AES-128 CBC core; commands only in IDLE (ready high), init before next, key held until ready
`timescale 1ns/1ps
`default_nettype none

module doe_core_cbc import doe_cipher_pkg::*, doe_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         reset_n,
  input  doe_cmd_t    cmd,
  input  doe_block_u  key,
  input  doe_block_u  iv,
  input  doe_block_u  block_msg,
  output doe_block_u  result,
  output doe_status_t status
);

  // ----------------------------------------
  // Control and data registers
  // ----------------------------------------
  doe_ctrl_state_e state_q;
  doe_status_t     status_q;

  // Direction latched at accepted next
  logic enc_sel_q;

  // One-cycle start to the selected datapath
  logic dp_next_q;

  // CBC chain and captured input block
  doe_block_u chain_q;
  doe_block_u in_q;
  doe_block_u result_q;

  // Submodule hookups
  logic       key_init;
  doe_round_t key_round;
  doe_block_u round_key;
  logic       key_ready;

  logic       enc_next;
  doe_round_t enc_round;
  doe_block_u enc_in;
  doe_block_u enc_new_block;
  logic       enc_ready;

  logic       dec_next;
  doe_round_t dec_round;
  doe_block_u dec_new_block;
  logic       dec_ready;

  // Command decode
  logic       accept;
  logic       next_go;
  logic       dp_ready;
  doe_block_u dec_plain;

  // Commands only count in IDLE, init wins over next
  assign accept  = (state_q == IDLE);
  assign next_go = accept & cmd.next & ~cmd.init;

  // Key memory starts in the same cycle init is sampled
  assign key_init = accept & cmd.init;

  // Datapath routing by latched direction
  assign enc_next  = dp_next_q & enc_sel_q;
  assign dec_next  = dp_next_q & ~enc_sel_q;
  assign key_round = enc_sel_q ? enc_round : dec_round;
  assign dp_ready  = enc_sel_q ? enc_ready : dec_ready;

  // Chain enters before encryption, leaves after decryption
  assign enc_in    = in_q ^ chain_q;
  assign dec_plain = dec_new_block ^ chain_q;

  // ----------------------------------------
  // Submodules
  // ----------------------------------------
  doe_key_mem u_key_mem (
    .clk       (clk),
    .reset_n   (reset_n),
    .key       (key),
    .init      (key_init),
    .round     (key_round),
    .round_key (round_key),
    .ready     (key_ready)
  );

  doe_encipher_block u_encipher (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (enc_next),
    .round     (enc_round),
    .round_key (round_key),
    .block_msg (enc_in),
    .new_block (enc_new_block),
    .ready     (enc_ready)
  );

  doe_decipher_block u_decipher (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (dec_next),
    .round     (dec_round),
    .round_key (round_key),
    .block_msg (in_q),
    .new_block (dec_new_block),
    .ready     (dec_ready)
  );

  // ----------------------------------------
  // Control FSM and chain register
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= IDLE;
      status_q  <= '{ready: 1'b1, result_valid: 1'b0};
      enc_sel_q <= 1'b1;
      dp_next_q <= 1'b0;
      chain_q   <= '0;
    end
    else
    begin
      dp_next_q <= 1'b0;
      // New IV also applies to a next in the same cycle
      if (accept && cmd.iv_load)
        chain_q <= iv;
      case (state_q)
        IDLE:
        begin
          if (cmd.init)
          begin
            state_q  <= INIT;
            status_q <= '0;
          end
          else if (cmd.next)
          begin
            state_q   <= NEXT;
            status_q  <= '0;
            enc_sel_q <= cmd.encdec;
            dp_next_q <= 1'b1;
          end
        end
        INIT:
        begin
          if (key_ready)
          begin
            state_q         <= IDLE;
            status_q.ready  <= 1'b1;
          end
        end
        NEXT:
        begin
          // Datapath ready is stale during the start pulse
          if (dp_ready && !dp_next_q)
          begin
            state_q  <= IDLE;
            status_q <= '{ready: 1'b1, result_valid: 1'b1};
            // Chain moves on to this block's ciphertext
            chain_q  <= enc_sel_q ? enc_new_block : in_q;
          end
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // Input capture and result register
  always_ff @(posedge clk)
  begin
    if (next_go)
      in_q <= block_msg;
    if (state_q == NEXT && dp_ready && !dp_next_q)
      result_q <= enc_sel_q ? enc_new_block : dec_plain;
  end

  assign result = result_q;
  assign status = status_q;

endmodule

`default_nettype wire

// File: hdl/doe_decipher_block.sv
// Inverse AES-128 rounds, one per clock, counting 10 down to 0; needs a full key schedule
`timescale 1ns/1ps
`default_nettype none

module doe_decipher_block import doe_cipher_pkg::*;
(
  input  wire        clk,
  input  wire        reset_n,
  input  wire        next,
  output doe_round_t round,
  input  doe_block_u round_key,
  input  doe_block_u block_msg,
  output doe_block_u new_block,
  output logic       ready
);

  doe_block_u state_q;

  // ----------------------------------------
  // Inverse round transforms
  // ----------------------------------------

  // InvMixColumns on one column
  function automatic logic [31:0] inv_mix_column(input logic [31:0] col);
    logic [3:0][7:0] a;
    logic [3:0][7:0] m;
    a = col;
    for (int r = 0; r < 4; r++)
      m[3 - r] = doe_gmul(a[3 - r], 4'd14) ^ doe_gmul(a[3 - (r + 1) % 4], 4'd11) ^
                 doe_gmul(a[3 - (r + 2) % 4], 4'd13) ^ doe_gmul(a[3 - (r + 3) % 4], 4'd9);
    return m;
  endfunction

  // InvShiftRows, InvSubBytes, AddRoundKey, InvMixColumns unless last
  function automatic doe_block_u dec_round(input doe_block_u s, input doe_block_u rk,
                                           input logic last);
    doe_block_u isr;
    doe_block_u isb;
    doe_block_u imc;
    // Row r rotates right by r columns
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        isr.bytes[15 - (4 * c + r)] = s.bytes[15 - (4 * ((c + 4 - r) % 4) + r)];
    for (int i = 0; i < 16; i++)
      isb.bytes[i] = doe_inv_sbox(isr.bytes[i]);
    isb.words = isb.words ^ rk.words;
    // Key add comes before the column mix here
    for (int c = 0; c < 4; c++)
      imc.words[c] = inv_mix_column(isb.words[c]);
    if (last)
      imc = isb;
    return imc;
  endfunction

  // ----------------------------------------
  // Round counter
  // ----------------------------------------

  // Idle value is 10 so the first key add uses the last round key
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      round <= DOE_NUM_ROUNDS[3:0];
      ready <= 1'b1;
    end
    else if (next)
    begin
      round <= DOE_NUM_ROUNDS[3:0] - 4'd1;
      ready <= 1'b0;
    end
    else if (!ready)
    begin
      if (round == '0)
      begin
        round <= DOE_NUM_ROUNDS[3:0];
        ready <= 1'b1;
      end
      else
        round <= round - 4'd1;
    end
  end

  // State block
  always_ff @(posedge clk)
  begin
    if (next)
      state_q.words <= block_msg.words ^ round_key.words;
    else if (!ready)
      state_q <= dec_round(state_q, round_key, round == '0);
  end

  // Raw output, CBC chain XOR happens in the core
  assign new_block = state_q;

endmodule

`default_nettype wire

// File: hdl/doe_encipher_block.sv
// One AES-128 round per clock; next must only pulse while ready is high
`timescale 1ns/1ps
`default_nettype none

module doe_encipher_block import doe_cipher_pkg::*;
(
  input  wire        clk,
  input  wire        reset_n,
  input  wire        next,
  output doe_round_t round,
  input  doe_block_u round_key,
  input  doe_block_u block_msg,
  output doe_block_u new_block,
  output logic       ready
);

  doe_block_u state_q;

  // ----------------------------------------
  // Round transforms
  // ----------------------------------------

  // MixColumns on one column, row 0 in the top byte
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [3:0][7:0] a;
    logic [3:0][7:0] m;
    a = col;
    for (int r = 0; r < 4; r++)
      m[3 - r] = doe_gmul(a[3 - r], 4'd2) ^ doe_gmul(a[3 - (r + 1) % 4], 4'd3) ^
                 a[3 - (r + 2) % 4] ^ a[3 - (r + 3) % 4];
    return m;
  endfunction

  // SubBytes, ShiftRows, MixColumns unless last, AddRoundKey
  function automatic doe_block_u enc_round(input doe_block_u s, input doe_block_u rk,
                                           input logic last);
    doe_block_u sb;
    doe_block_u sr;
    doe_block_u mc;
    for (int i = 0; i < 16; i++)
      sb.bytes[i] = doe_sbox(s.bytes[i]);
    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        sr.bytes[15 - (4 * c + r)] = sb.bytes[15 - (4 * ((c + r) % 4) + r)];
    for (int c = 0; c < 4; c++)
      mc.words[c] = mix_column(sr.words[c]);
    if (last)
      mc = sr;
    mc.words = mc.words ^ rk.words;
    return mc;
  endfunction

  // ----------------------------------------
  // Round counter
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      round <= '0;
      ready <= 1'b1;
    end
    else if (next)
    begin
      round <= 4'd1;
      ready <= 1'b0;
    end
    else if (!ready)
    begin
      // Back to 0 so the next block starts with key 0
      if (round == DOE_NUM_ROUNDS)
      begin
        round <= '0;
        ready <= 1'b1;
      end
      else
        round <= round + 4'd1;
    end
  end

  // State block, initial key add on next
  always_ff @(posedge clk)
  begin
    if (next)
      state_q.words <= block_msg.words ^ round_key.words;
    else if (!ready)
      state_q <= enc_round(state_q, round_key, round == DOE_NUM_ROUNDS);
  end

  assign new_block = state_q;

endmodule

`default_nettype wire

// File: hdl/doe_key_mem.sv
// AES-128 key schedule only; key must hold steady for the cycle init is sampled
`timescale 1ns/1ps
`default_nettype none

module doe_key_mem import doe_cipher_pkg::*;
(
  input  wire        clk,
  input  wire        reset_n,
  input  doe_block_u key,
  input  wire        init,
  input  doe_round_t round,
  output doe_block_u round_key,
  output logic       ready
);

  // Stored schedule, one entry per round
  doe_block_u round_keys [DOE_NUM_ROUNDS + 1];

  // Key being derived from and its index
  doe_block_u last_key;
  doe_block_u next_key;
  doe_round_t exp_round;

  logic [3:0][7:0] rot_word;
  logic [3:0][7:0] sub_word;
  logic [31:0]     temp_word;

  // ----------------------------------------
  // One schedule step
  // ----------------------------------------
  always_comb
  begin
    // RotWord on the last column
    rot_word = {last_key.words[0][23:0], last_key.words[0][31:24]};
    for (int i = 0; i < 4; i++)
      sub_word[i] = doe_sbox(rot_word[i]);
    temp_word = sub_word ^ {doe_rcon(exp_round), 24'h000000};
    // Each column folds in the one before it
    next_key.words[3] = last_key.words[3] ^ temp_word;
    next_key.words[2] = last_key.words[2] ^ next_key.words[3];
    next_key.words[1] = last_key.words[1] ^ next_key.words[2];
    next_key.words[0] = last_key.words[0] ^ next_key.words[1];
  end

  // ----------------------------------------
  // Expansion control and storage
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i <= DOE_NUM_ROUNDS; i++)
        round_keys[i] <= '0;
      exp_round <= '0;
      ready     <= 1'b1;
    end
    else if (init)
    begin
      // Round key 0 is the cipher key itself
      round_keys[0] <= key;
      exp_round     <= 4'd1;
      ready         <= 1'b0;
    end
    else if (!ready)
    begin
      round_keys[exp_round] <= next_key;
      if (exp_round == DOE_NUM_ROUNDS)
        ready <= 1'b1;
      else
        exp_round <= exp_round + 4'd1;
    end
  end

  // Seed for the next step, no reset needed before first init
  always_ff @(posedge clk)
  begin
    if (init)
      last_key <= key;
    else if (!ready)
      last_key <= next_key;
  end

  // Read port, combinational
  assign round_key = round_keys[round];

endmodule

`default_nettype wire

// File: hdl/doe_ctrl_pkg.sv
// Command bits are single-cycle strobes; the core samples them only while ready is high
`default_nettype none

package doe_ctrl_pkg;

  // ----------------------------------------
  // Top-level command and status
  // ----------------------------------------

  // encdec 1 selects encryption, latched when next is accepted
  typedef struct packed
  {
    logic encdec;
    logic init;
    logic next;
    logic iv_load;
  } doe_cmd_t;

  // result_valid only rises together with ready
  typedef struct packed
  {
    logic ready;
    logic result_valid;
  } doe_status_t;

  // Core control FSM
  typedef enum logic [1:0] {IDLE, INIT, NEXT} doe_ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/doe_cipher_pkg.sv
// AES-128 only; state byte 0 sits in bits [127:120], column 0 in bits [127:96]
`default_nettype none

package doe_cipher_pkg;

  // ----------------------------------------
  // Sizes and basic types
  // ----------------------------------------

  // AES-128 has ten full rounds after the initial key add
  localparam int DOE_NUM_ROUNDS = 10;

  // Round index, 0 to 10
  typedef logic [3:0] doe_round_t;

  // One 128-bit block, seen as bytes or as column words
  // bytes[15] and words[3] are the leftmost (first) byte and column
  typedef union packed
  {
    logic [15:0][7:0] bytes;
    logic [3:0][31:0] words;
  } doe_block_u;

  // ----------------------------------------
  // Lookup tables
  // ----------------------------------------

  // Forward S-box, entry 0 in the top byte
  localparam logic [0:255][7:0] DOE_SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Inverse S-box, same layout
  localparam logic [0:255][7:0] DOE_INV_SBOX = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  // Round constants, index 0 unused
  localparam logic [0:10][7:0] DOE_RCON = {
    8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // ----------------------------------------
  // Byte functions
  // ----------------------------------------

  function automatic logic [7:0] doe_sbox(input logic [7:0] b);
    return DOE_SBOX[b];
  endfunction

  function automatic logic [7:0] doe_inv_sbox(input logic [7:0] b);
    return DOE_INV_SBOX[b];
  endfunction

  // GF(2^8) product with a 4-bit constant, shift and add
  function automatic logic [7:0] doe_gmul(input logic [7:0] b, input logic [3:0] c);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = b;
    for (int i = 0; i < 4; i++)
    begin
      if (c[i])
        acc = acc ^ p;
      // xtime, reduce by x^8 + x^4 + x^3 + x + 1
      p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  // Zero outside rounds 1 to 10
  function automatic logic [7:0] doe_rcon(input doe_round_t round);
    return (round <= DOE_NUM_ROUNDS) ? DOE_RCON[round] : 8'h00;
  endfunction

endpackage

`default_nettype wire
